/* files.f */
+incdir+hw
hw/memReqPkg.sv
hw/memPwrPkg.sv
hw/memLatencyPipe.sv
hw/memBankDemux.sv
hw/memBankArray.sv
hw/memReadMux.sv
hw/memMultibankPwr.sv
test/tbClkRst.sv
test/tbMemMultibankPwr.sv

/* hw/memBankArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module memBankArray
   import memReqPkg::*;
   import memPwrPkg::*;
#(
   parameter int unsigned NumWords = `MEM_NUM_WORDS / `MEM_NUM_BANKS  // Words in this bank
) (
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  bankPwrT                       pwr_i,
   input  bankReqT [`MEM_NUM_PORTS-1:0]  req_i,
   output dataT    [`MEM_NUM_PORTS-1:0]  rdata_o
);

   dataT memQ [NumWords];                 // Storage, no reset
   dataT [`MEM_NUM_PORTS-1:0] rdWord;     // Read word before the latency pipe
   logic awake;

   // Any power control set blocks all access
   assign awake = !pwr_i.deepSleep && !pwr_i.powerGate;

   // Writes land on the edge where the request is seen
   always_ff @(posedge clk_i) begin
      if (pwr_i.powerGate) begin
         // Contents lost while off
         for (int w = 0; w < NumWords; w++) begin
            memQ[w] <= '0;
         end
      end else if (!pwr_i.deepSleep) begin
         // Port order, so the higher port wins per byte
         for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
            if (req_i[p].req && req_i[p].we) begin
               for (int i = 0; i < `MEM_BE_WIDTH; i++) begin
                  if (req_i[p].be[i]) begin
                     memQ[req_i[p].addr][i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH] <=
                        req_i[p].wdata[i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH];
                  end
               end
            end
         end
      end
   end

   for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : genPort
      // Samples contents before this edge's writes
      assign rdWord[p] = (awake && req_i[p].req && !req_i[p].we) ? memQ[req_i[p].addr] : '0;

      memLatencyPipe #(
         .Depth    (`MEM_LATENCY),
         .payloadT (dataT)
      ) iRdPipe (
         .clk_i,
         .rst_ni,
         .data_i (rdWord[p]),
         .data_o (rdata_o[p])   // Zero unless a read of an awake bank
      );
   end

endmodule

`default_nettype wire

/* hw/memBankDemux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module memBankDemux
   import memReqPkg::*;
(
   input  memReqT  [`MEM_NUM_PORTS-1:0]                     req_i,
   output bankReqT [`MEM_NUM_BANKS-1:0][`MEM_NUM_PORTS-1:0] bankReq_o,
   output bankSelT [`MEM_NUM_PORTS-1:0]                     bankSel_o
);

   bankSelT [`MEM_NUM_PORTS-1:0] bankSel;  // Decoded index per port

   // Top address bits name the bank
   for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : genSel
      assign bankSel[p] = req_i[p].addr[`MEM_ADDR_WIDTH-1 -: `MEM_BANK_SEL_WIDTH];
   end

   assign bankSel_o = bankSel;  // Read mux tracks it down the pipe

   for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : genBank
      for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : genPort
         logic hit;  // Port p targets bank b this cycle

         assign hit = req_i[p].req && (bankSel[p] == bankSelT'(b));

         always_comb begin
            bankReq_o[b][p] = '0;  // Banks not addressed see nothing
            if (hit) begin
               bankReq_o[b][p].req   = 1'b1;
               bankReq_o[b][p].we    = req_i[p].we;
               // Keep only the in-bank offset
               bankReq_o[b][p].addr  = req_i[p].addr[`MEM_BANK_ADDR_WIDTH-1:0];
               bankReq_o[b][p].wdata = req_i[p].wdata;
               bankReq_o[b][p].be    = req_i[p].be;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hw/memLatencyPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module memLatencyPipe #(
   parameter int unsigned Depth = 1,       // Number of register stages
   parameter type         payloadT = logic // Any packed payload
) (
   input  logic    clk_i,
   input  logic    rst_ni,
   input  payloadT data_i,
   output payloadT data_o
);

   payloadT [Depth-1:0] stageQ;  // Stage 0 is the input side

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         stageQ <= '0;  // Pipe comes up empty
      end else begin
         stageQ[0] <= data_i;
         // Shift towards the output
         for (int i = 1; i < Depth; i++) begin
            stageQ[i] <= stageQ[i-1];
         end
      end
   end

   assign data_o = stageQ[Depth-1];  // Oldest entry

endmodule

`default_nettype wire

/* hw/memMultibankPwr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module memMultibankPwr
   import memReqPkg::*;
   import memPwrPkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_ni,
   input  memReqT [`MEM_NUM_PORTS-1:0]  req_i,    // One request per port
   input  bankPwrVecT                   pwr_i,    // One control pair per bank
   output dataT   [`MEM_NUM_PORTS-1:0]  rdata_o   // Valid MEM_LATENCY cycles after a read
);

   localparam int unsigned BankWords = `MEM_NUM_WORDS / `MEM_NUM_BANKS;

   bankReqT [`MEM_NUM_BANKS-1:0][`MEM_NUM_PORTS-1:0] bankReq;    // Demux to banks
   dataT    [`MEM_NUM_BANKS-1:0][`MEM_NUM_PORTS-1:0] bankRdata;  // Banks to read mux
   bankSelT [`MEM_NUM_PORTS-1:0]                     bankSel;    // Demux to read mux

   // Steer each port to one bank
   memBankDemux iDemux (
      .req_i,
      .bankReq_o (bankReq),
      .bankSel_o (bankSel)
   );

   // Contiguous logic banks, each under its own power control
   for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : genBank
      memBankArray #(
         .NumWords (BankWords)
      ) iBank (
         .clk_i,
         .rst_ni,
         .pwr_i   (pwr_i[b]),
         .req_i   (bankReq[b]),
         .rdata_o (bankRdata[b])
      );
   end

   // Pick the returning bank per port
   memReadMux iReadMux (
      .clk_i,
      .rst_ni,
      .bankSel_i   (bankSel),
      .bankRdata_i (bankRdata),
      .rdata_o
   );

endmodule

`default_nettype wire

/* hw/memPwrPkg.sv */
`default_nettype none

`include "mem_params.svh"

package memPwrPkg;

   // Power controls of one logic bank
   typedef struct packed {
      logic deepSleep;  // Retention, contents kept, no access
      logic powerGate;  // Off, contents lost
   } bankPwrT;

   // One control pair per bank
   typedef bankPwrT [`MEM_NUM_BANKS-1:0] bankPwrVecT;

endpackage

`default_nettype wire

/* hw/memReadMux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module memReadMux
   import memReqPkg::*;
(
   input  logic                                             clk_i,
   input  logic                                             rst_ni,
   input  bankSelT [`MEM_NUM_PORTS-1:0]                     bankSel_i,
   input  dataT    [`MEM_NUM_BANKS-1:0][`MEM_NUM_PORTS-1:0] bankRdata_i,
   output dataT    [`MEM_NUM_PORTS-1:0]                     rdata_o
);

   bankSelT [`MEM_NUM_PORTS-1:0] selQ;  // Bank index of the returning read

   for (genvar p = 0; p < `MEM_NUM_PORTS; p++) begin : genPort
      // Same depth as the bank data pipe
      memLatencyPipe #(
         .Depth    (`MEM_LATENCY),
         .payloadT (bankSelT)
      ) iSelPipe (
         .clk_i,
         .rst_ni,
         .data_i (bankSel_i[p]),
         .data_o (selQ[p])
      );

      // Unselected banks return zero anyway, so idle cycles read zero
      assign rdata_o[p] = bankRdata_i[selQ[p]][p];
   end

endmodule

`default_nettype wire

/* hw/memReqPkg.sv */
`default_nettype none

`include "mem_params.svh"

package memReqPkg;

   typedef logic [`MEM_ADDR_WIDTH-1:0]      addrT;      // Full word address
   typedef logic [`MEM_BANK_ADDR_WIDTH-1:0] bankAddrT;  // Bank-local low bits
   typedef logic [`MEM_BANK_SEL_WIDTH-1:0]  bankSelT;   // Top address bits
   typedef logic [`MEM_DATA_WIDTH-1:0]      dataT;
   typedef logic [`MEM_BE_WIDTH-1:0]        beT;        // One bit per byte

   // One port's request as issued from outside
   typedef struct packed {
      logic req;    // Request strobe
      logic we;     // Write when set, else read
      addrT addr;
      dataT wdata;
      beT   be;
   } memReqT;

   // Same request after bank decode
   typedef struct packed {
      logic     req;
      logic     we;
      bankAddrT addr;   // Bank index stripped
      dataT     wdata;
      beT       be;
   } bankReqT;

endpackage

`default_nettype wire

/* hw/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Memory geometry
`define MEM_NUM_WORDS  256   // Total words over all banks
`define MEM_DATA_WIDTH 32
`define MEM_BYTE_WIDTH 8
`define MEM_NUM_PORTS  2
`define MEM_LATENCY    2     // Read latency in cycles, at least 1
`define MEM_NUM_BANKS  4     // Power of two

// Derived widths
`define MEM_ADDR_WIDTH      ($clog2(`MEM_NUM_WORDS))
`define MEM_BE_WIDTH        ((`MEM_DATA_WIDTH + `MEM_BYTE_WIDTH - 1) / `MEM_BYTE_WIDTH)
`define MEM_BANK_SEL_WIDTH  ($clog2(`MEM_NUM_BANKS))
// Bank index sits in the top bits, so banks stay contiguous
`define MEM_BANK_ADDR_WIDTH (`MEM_ADDR_WIDTH - `MEM_BANK_SEL_WIDTH)

`endif

/* run.sh */
#!/bin/sh
# Build and run the multibank memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f files.f --top-module tbMemMultibankPwr \
   -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# Decide from the log
if grep -q "TESTBENCH PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/tbClkRst.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClkRst #(
   parameter int unsigned HalfPeriod  = 4,  // 8 ns clock period
   parameter int unsigned ResetCycles = 3
) (
   output logic clk_o,
   output logic rst_no
);

   initial begin
      clk_o = 1'b0;
      forever #(HalfPeriod) clk_o = ~clk_o;
   end

   // Active-low reset, released on a rising edge
   initial begin
      rst_no = 1'b0;
      repeat (ResetCycles) @(posedge clk_o);
      rst_no <= 1'b1;
   end

endmodule

`default_nettype wire

/* test/tbMemMultibankPwr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tbMemMultibankPwr
   import memReqPkg::*;
   import memPwrPkg::*;
();

   // One expected read word tagged with the cycle it shows up
   typedef struct packed {
      logic [31:0] due;
      dataT        word;
   } expT;

   logic                        clk;
   logic                        rstN;
   memReqT [`MEM_NUM_PORTS-1:0] req;
   bankPwrVecT                  pwr;
   dataT   [`MEM_NUM_PORTS-1:0] rdata;

   dataT        refMem [`MEM_NUM_WORDS];     // Reference contents
   expT         expQ [`MEM_NUM_PORTS][$];    // Pending expected words per port
   int unsigned cycle    = 0;                // Edges seen since reset release
   int          seed     = 32'h2d2d;
   int          checks   = 0;
   int          errors   = 0;
   int          timeouts = 0;

   tbClkRst iClkRst (.clk_o(clk), .rst_no(rstN));

   memMultibankPwr i_dut (
      .clk_i   (clk),
      .rst_ni  (rstN),
      .req_i   (req),
      .pwr_i   (pwr),
      .rdata_o (rdata)
   );

   function automatic bankSelT bankOf(input addrT a);
      return bankSelT'(a >> `MEM_BANK_ADDR_WIDTH);  // Top address bits
   endfunction

   function automatic logic awake(input bankSelT s);
      return !pwr[s].deepSleep && !pwr[s].powerGate;
   endfunction

   // Expected read word for one request from contents before the edge
   function automatic dataT expRead(input memReqT r);
      if (r.req && !r.we && awake(bankOf(r.addr))) return refMem[r.addr];
      return '0;  // Idle, write or sleeping bank
   endfunction

   function automatic memReqT wrReq(input addrT a, input dataT d, input beT be);
      memReqT r;
      r       = '0;
      r.req   = 1'b1;
      r.we    = 1'b1;
      r.addr  = a;
      r.wdata = d;
      r.be    = be;
      return r;
   endfunction

   function automatic memReqT rdReq(input addrT a);
      memReqT r;
      r      = '0;
      r.req  = 1'b1;
      r.addr = a;
      return r;
   endfunction

   function automatic addrT bankWord(input int b, input int off);
      return addrT'((b << `MEM_BANK_ADDR_WIDTH) | (off & ((1 << `MEM_BANK_ADDR_WIDTH) - 1)));
   endfunction

   function automatic addrT bankAddr(input int b);
      return bankWord(b, $random(seed));  // Random word inside bank b
   endfunction

   // Initial contents where every address bit shows up in the word
   function automatic dataT fillWord(input int w);
      return (dataT'(w) << 20) ^ (dataT'(w) << 8) ^ dataT'(w) ^ 32'ha55a_3cc3;
   endfunction

   function automatic memReqT randReq();
      addrT a;
      a = addrT'($random(seed));
      if ($random(seed) & 1) return wrReq(a, dataT'($random(seed)), beT'($random(seed)));
      return rdReq(a);
   endfunction

   task automatic drive(input memReqT r0, input memReqT r1);
      @(posedge clk);
      req[0] <= r0;
      req[1] <= r1;
   endtask

   task automatic setPwr(input int b, input logic ds, input logic pg);
      @(posedge clk);
      pwr[b].deepSleep <= ds;
      pwr[b].powerGate <= pg;
      req              <= '0;  // No traffic in the switching cycle
   endtask

   task automatic waitReset();
      int n;
      n = 0;
      while (!rstN && n < 20) begin
         @(posedge clk);
         n++;
      end
      if (!rstN) begin
         timeouts++;
         $display("timeout: reset was never released");
      end
   endtask

   // Idle until every issued read has come back
   task automatic settle();
      int unsigned endCycle;
      int          n;
      endCycle = cycle + `MEM_LATENCY + 2;
      n        = 0;
      while (cycle < endCycle && n < 50) begin
         drive('0, '0);
         n++;
      end
      if (cycle < endCycle) begin
         timeouts++;
         $display("timeout: outstanding reads did not drain");
      end
   endtask

   // Reference model sees the same request the DUT samples at this edge
   always @(posedge clk) begin : refModel
      expT     e;
      bankSelT s;
      if (rstN) begin
         for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
            e.due  = cycle + `MEM_LATENCY;
            e.word = expRead(req[p]);  // Old data before this edge's writes
            expQ[p].push_back(e);
         end
         for (int w = 0; w < `MEM_NUM_WORDS; w++) begin
            if (pwr[bankOf(addrT'(w))].powerGate) refMem[w] = '0;  // Gated words lost
         end
         // Port order so the higher port overwrites per byte
         for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
            s = bankOf(req[p].addr);
            if (req[p].req && req[p].we && awake(s)) begin
               for (int i = 0; i < `MEM_BE_WIDTH; i++) begin
                  if (req[p].be[i])
                     refMem[req[p].addr][i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH] =
                        req[p].wdata[i*`MEM_BYTE_WIDTH +: `MEM_BYTE_WIDTH];
               end
            end
         end
         cycle <= cycle + 1;
      end
   end

   // Compare every due word including idle cycles
   always @(posedge clk) begin : compare
      expT e;
      if (rstN) begin
         for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
            if (expQ[p].size() != 0 && expQ[p][0].due == cycle) begin
               e = expQ[p].pop_front();
               checks++;
               if (rdata[p] !== e.word) begin
                  errors++;
                  $display("mismatch at %0t: rdata_o[%0d] got %h expected %h",
                           $time, p, rdata[p], e.word);
               end
            end
         end
      end
   end

   initial begin : stimulus
      addrT a;
      expT  e;
      req = '0;
      pwr = '0;
      // Read pipes leave reset empty so the first words out are zero
      for (int p = 0; p < `MEM_NUM_PORTS; p++) begin
         for (int c = 0; c < `MEM_LATENCY; c++) begin
            e.due  = c;
            e.word = '0;
            expQ[p].push_back(e);
         end
      end
      waitReset();
      repeat (8) drive('0, '0);  // Quiet outputs after reset
      // Fill the whole memory two words per cycle
      for (int w = 0; w < `MEM_NUM_WORDS; w += 2) begin
         drive(wrReq(addrT'(w), fillWord(w), '1), wrReq(addrT'(w + 1), fillWord(w + 1), '1));
      end
      // Byte-masked writes in every bank
      for (int i = 0; i < 32; i++) begin
         drive(wrReq(bankAddr(i % 4), dataT'($random(seed)), beT'($random(seed))),
               wrReq(bankAddr((i + 2) % 4), dataT'($random(seed)), beT'($random(seed))));
      end
      // Back-to-back reads alternating banks
      for (int i = 0; i < 48; i++) drive(rdReq(bankAddr(i % 4)), rdReq(bankAddr((i + 1) % 4)));
      for (int i = 0; i < 40; i++) drive(randReq(), randReq());
      // Same word from both ports with overlapping masks
      a = bankAddr(1);
      drive(wrReq(a, 32'h1111_1111, beT'(4'b0011)), wrReq(a, 32'h2222_2222, beT'(4'b0110)));
      drive(rdReq(a), '0);
      drive(rdReq(a), wrReq(a, 32'h3333_3333, '1));  // Read returns old data
      drive(rdReq(a), '0);
      // Deep sleep keeps bank 2 but blocks it
      a = bankAddr(2);
      setPwr(2, 1'b1, 1'b0);
      drive(wrReq(a, 32'hdead_beef, '1), rdReq(bankAddr(0)));
      drive(rdReq(a), rdReq(bankAddr(3)));
      setPwr(2, 1'b0, 1'b0);
      for (int i = 0; i < 6; i++) drive(rdReq(a), rdReq(bankWord(2, i)));
      // Power gate wipes bank 3 only
      setPwr(3, 1'b0, 1'b1);
      repeat (4) drive('0, '0);
      setPwr(3, 1'b0, 1'b0);
      for (int i = 0; i < 8; i++) drive(rdReq(bankWord(3, i)), rdReq(bankWord(0, i)));
      settle();
      $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0 && checks > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
